// ==== rv_core.f ====
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_fetch_queue.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core_top.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

// ==== Makefile ====
TOP := rv_core_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f rv_core.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam int NUM_PROGS   = 3;
    localparam int NUM_TESTS   = 2 * NUM_PROGS;
    localparam int PROG_WORDS  = 8;
    localparam int CYCLE_LIMIT = NUM_TESTS * 200;
    // JAL x0, 0 spins on its own address
    localparam logic [XLEN-1:0] JAL_SELF = 32'h0000006f;

    logic              clk          = 1'b0;
    logic              i_rst_n      = 1'b0;
    logic [XLEN-1:0]   i_imem_data  = JAL_SELF;
    logic              i_imem_ack_n = 1'b1;
    logic [XLEN-1:0]   o_imem_addr;
    logic              o_retire_valid;
    logic [XLEN-1:0]   o_retire_pc;
    logic [REG_AW-1:0] o_retire_rd;
    logic [XLEN-1:0]   o_retire_data;

    // Program words and the retire sequence each one must produce
    logic [XLEN-1:0]   prog_mem  [NUM_PROGS][PROG_WORDS];
    int                exp_count [NUM_PROGS];
    logic [XLEN-1:0]   exp_pc    [NUM_PROGS][PROG_WORDS];
    logic [REG_AW-1:0] exp_rd    [NUM_PROGS][PROG_WORDS];
    logic [XLEN-1:0]   exp_data  [NUM_PROGS][PROG_WORDS];

    int          cur_prog  = 0;
    logic        gaps_on   = 1'b0;
    logic [31:0] lcg_state = 32'd79;
    int          cycles    = 0;
    int          checks    = 0;
    int          errors    = 0;

    rv_core_top dut_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .o_imem_addr    (o_imem_addr),
        .i_imem_data    (i_imem_data),
        .i_imem_ack_n   (i_imem_ack_n),
        .o_retire_valid (o_retire_valid),
        .o_retire_pc    (o_retire_pc),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_branch(input int f3, input int rs1, input int rs2,
                                               input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Word-addressed memory where anything past the program spins
    function automatic logic [XLEN-1:0] imem_word(input logic [XLEN-1:0] addr);
        if (addr[XLEN-1:5] != '0) begin
            return JAL_SELF;
        end
        return prog_mem[cur_prog][addr[4:2]];
    endfunction

    task automatic place_retiring(input int p, input int w, input logic [31:0] instr,
                                  input int rd, input logic [31:0] data);
        prog_mem[p][w]            = instr;
        exp_pc[p][exp_count[p]]   = 4 * w;
        exp_rd[p][exp_count[p]]   = rd[4:0];
        exp_data[p][exp_count[p]] = data;
        exp_count[p]++;
    endtask

    task automatic build_table();
        for (int p = 0; p < NUM_PROGS; p++) begin
            exp_count[p] = 0;
            for (int w = 0; w < PROG_WORDS; w++) begin
                prog_mem[p][w] = JAL_SELF;
            end
        end
        // ALU ops and LUI reading the previous results
        place_retiring(0, 0, enc_addi(1, 0, 5), 1, 32'h5);
        place_retiring(0, 1, enc_addi(2, 0, 19), 2, 32'h13);
        place_retiring(0, 2, enc_r(0, 0, 3, 1, 2), 3, 32'h18);
        place_retiring(0, 3, enc_r(32, 0, 4, 2, 1), 4, 32'he);
        place_retiring(0, 4, enc_r(0, 4, 5, 1, 2), 5, 32'h16);
        place_retiring(0, 5, enc_r(0, 6, 6, 1, 2), 6, 32'h17);
        place_retiring(0, 6, enc_r(0, 7, 7, 1, 2), 7, 32'h1);
        place_retiring(0, 7, enc_lui(8, 32'habcde), 8, 32'habcde000);
        // Forwarding chain on x1 and x4 plus a write to x0
        place_retiring(1, 0, enc_addi(1, 0, 1), 1, 32'h1);
        place_retiring(1, 1, enc_addi(1, 1, 2), 1, 32'h3);
        place_retiring(1, 2, enc_r(0, 0, 1, 1, 1), 1, 32'h6);
        place_retiring(1, 3, enc_addi(0, 1, 7), 0, 32'h0);
        place_retiring(1, 4, enc_r(0, 0, 2, 0, 1), 2, 32'h6);
        place_retiring(1, 5, enc_lui(4, 1), 4, 32'h1000);
        place_retiring(1, 6, enc_addi(4, 4, -1), 4, 32'hfff);
        place_retiring(1, 7, enc_r(32, 0, 5, 0, 4), 5, 32'hfffff001);
        // Untaken BEQ, taken BNE, JAL link, taken BEQ off the end
        place_retiring(2, 0, enc_addi(1, 0, 3), 1, 32'h3);
        place_retiring(2, 1, enc_branch(0, 1, 0, 8), 0, 32'h0);
        place_retiring(2, 2, enc_branch(1, 1, 0, 8), 0, 32'h0);
        prog_mem[2][3] = enc_addi(2, 0, 99);
        place_retiring(2, 4, enc_jal(5, 8), 5, 32'h14);
        prog_mem[2][5] = enc_addi(3, 0, 77);
        place_retiring(2, 6, enc_addi(6, 5, 1), 6, 32'h15);
        place_retiring(2, 7, enc_branch(0, 6, 6, 8), 0, 32'h0);
    endtask

    // Memory response and ack gaps driven just after the edge
    always @(posedge clk) begin
        #1;
        lcg_state    = lcg_next(lcg_state);
        i_imem_ack_n = gaps_on && (lcg_state[31:30] == 2'b00);
        i_imem_data  = imem_word(o_imem_addr);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, expected retirements never arrived", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_retire(input int idx);
        checks += 3;
        assert (o_retire_pc == exp_pc[cur_prog][idx]) else begin
            $display("Error: o_retire_pc = %h, expected %h", o_retire_pc,
                     exp_pc[cur_prog][idx]);
            errors++;
        end
        assert (o_retire_rd == exp_rd[cur_prog][idx]) else begin
            $display("Error: o_retire_rd = %h, expected %h", o_retire_rd,
                     exp_rd[cur_prog][idx]);
            errors++;
        end
        assert (o_retire_data == exp_data[cur_prog][idx]) else begin
            $display("Error: o_retire_data = %h, expected %h", o_retire_data,
                     exp_data[cur_prog][idx]);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        int idx;
        int errs_before;
        errs_before = errors;
        @(posedge clk);
        #1;
        i_rst_n  = 1'b0;
        cur_prog = t % NUM_PROGS;
        gaps_on  = (t >= NUM_PROGS);
        repeat (16) @(posedge clk);
        checks += 2;
        assert (o_retire_valid == 1'b0) else begin
            $display("Error: o_retire_valid = %h in reset, expected 0", o_retire_valid);
            errors++;
        end
        // Programs start at address zero
        assert (o_imem_addr == 32'h0) else begin
            $display("Error: o_imem_addr = %h in reset, expected %h", o_imem_addr, 32'h0);
            errors++;
        end
        #1;
        i_rst_n = 1'b1;
        idx = 0;
        while (idx < exp_count[cur_prog]) begin
            @(negedge clk);
            if (o_retire_valid) begin
                check_retire(idx);
                idx++;
            end
        end
        $display("Test %0d: program %0d, ack gaps %0d, %0d retired, %0d errors",
                 t, cur_prog, gaps_on, idx, errors - errs_before);
    endtask

    initial begin
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/rv_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
    input wire                      clk,
    input wire                      i_rst_n,
    input wire                      i_push,
    input wire                      i_full,
    input wire                      i_pop,
    input wire                      i_valid,
    input wire                      i_redirect,
    input wire [rv_pkg::XLEN-1:0]   i_issue_pc,
    input wire                      i_retire_valid,
    input wire [rv_pkg::XLEN-1:0]   i_retire_pc
);

    no_push_when_full: assert property (
        @(posedge clk) disable iff (!i_rst_n) !(i_push && i_full)
    ) else $error("fetch queue pushed while full");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!i_rst_n) !(i_pop && !i_valid)
    ) else $error("fetch queue popped while empty");

    // Instruction issued under a redirect must not reach retire
    no_discarded_retire: assert property (
        @(posedge clk) disable iff (!i_rst_n)
            ($past(i_redirect, 2) && $past(i_valid, 2)) |->
                !(i_retire_valid && (i_retire_pc == $past(i_issue_pc, 2)))
    ) else $error("discarded instruction at pc %h retired", i_retire_pc);

endmodule

bind rv_fetch_queue rv_core_checker queue_chk (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_push         (i_push),
    .i_full         (o_full),
    .i_pop          (i_pop),
    .i_valid        (o_valid),
    .i_redirect     (1'b0),
    .i_issue_pc     ('0),
    .i_retire_valid (1'b0),
    .i_retire_pc    ('0)
);

bind rv_execute rv_core_checker exec_chk (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_push         (1'b0),
    .i_full         (1'b0),
    .i_pop          (o_pop),
    .i_valid        (i_valid),
    .i_redirect     (o_redirect),
    .i_issue_pc     (i_pc),
    .i_retire_valid (o_retire_valid),
    .i_retire_pc    (o_retire_pc)
);

`default_nettype wire

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  wire                       clk,
    input  wire                       i_rst_n,

    // Instruction memory, ack is active low
    output logic [rv_pkg::XLEN-1:0]   o_imem_addr,
    input  wire [rv_pkg::XLEN-1:0]    i_imem_data,
    input  wire                       i_imem_ack_n,

    // Retire report
    output logic                      o_retire_valid,
    output logic [rv_pkg::XLEN-1:0]   o_retire_pc,
    output logic [rv_pkg::REG_AW-1:0] o_retire_rd,
    output logic [rv_pkg::XLEN-1:0]   o_retire_data
);
    import rv_pkg::*;

    logic            push;
    logic            queue_full;
    logic            queue_valid;
    logic [XLEN-1:0] head_pc;
    logic [XLEN-1:0] head_instr;
    logic            pop;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    rv_fetch fetch_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_imem_ack_n  (i_imem_ack_n),
        .i_full        (queue_full),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_imem_addr   (o_imem_addr),
        .o_push        (push)
    );

    // Queue is flushed by the same redirect that reloads the pc
    rv_fetch_queue queue_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_push       (push),
        .i_push_pc    (o_imem_addr),
        .i_push_instr (i_imem_data),
        .i_pop        (pop),
        .i_flush      (redirect),
        .o_full       (queue_full),
        .o_valid      (queue_valid),
        .o_head_pc    (head_pc),
        .o_head_instr (head_instr)
    );

    rv_execute execute_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (queue_valid),
        .i_pc           (head_pc),
        .i_instr        (head_instr),
        .o_pop          (pop),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_retire_valid (o_retire_valid),
        .o_retire_pc    (o_retire_pc),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data)
    );

endmodule

`default_nettype wire

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_valid,
    input  wire [rv_pkg::XLEN-1:0]    i_pc,
    input  wire [rv_pkg::XLEN-1:0]    i_instr,
    output logic                      o_pop,
    output logic                      o_redirect,
    output logic [rv_pkg::XLEN-1:0]   o_redirect_pc,
    output logic                      o_retire_valid,
    output logic [rv_pkg::XLEN-1:0]   o_retire_pc,
    output logic [rv_pkg::REG_AW-1:0] o_retire_rd,
    output logic [rv_pkg::XLEN-1:0]   o_retire_data
);
    import rv_pkg::*;

    logic [REG_AW-1:0]   dec_rs1;
    logic [REG_AW-1:0]   dec_rs2;
    logic [REG_AW-1:0]   dec_rd;
    logic [ALU_OP_W-1:0] dec_alu_op;
    logic                dec_use_imm;
    logic [XLEN-1:0]     dec_imm;
    logic                dec_is_branch;
    logic                dec_branch_ne;
    logic                dec_is_jal;
    logic                dec_wr_en;
    logic                dec_legal;
    logic [XLEN-1:0]     rf_rs1_data;
    logic [XLEN-1:0]     rf_rs2_data;
    logic [XLEN-1:0]     issue_rs1_val;
    logic [XLEN-1:0]     issue_rs2_val;

    // Execute stage state
    logic                ex_valid;
    logic [XLEN-1:0]     ex_pc;
    logic [XLEN-1:0]     ex_rs1_val;
    logic [XLEN-1:0]     ex_rs2_val;
    logic [XLEN-1:0]     ex_imm;
    logic [ALU_OP_W-1:0] ex_alu_op;
    logic                ex_use_imm;
    logic                ex_is_branch;
    logic                ex_branch_ne;
    logic                ex_is_jal;
    logic                ex_wr_en;
    logic [REG_AW-1:0]   ex_rd;
    logic [XLEN-1:0]     alu_b;
    logic [XLEN-1:0]     alu_result;
    logic [XLEN-1:0]     ex_result;
    logic                ex_write;
    logic                branch_taken;

    rv_decode decode_inst (
        .i_instr     (i_instr),
        .o_rs1       (dec_rs1),
        .o_rs2       (dec_rs2),
        .o_rd        (dec_rd),
        .o_alu_op    (dec_alu_op),
        .o_use_imm   (dec_use_imm),
        .o_imm       (dec_imm),
        .o_is_branch (dec_is_branch),
        .o_branch_ne (dec_branch_ne),
        .o_is_jal    (dec_is_jal),
        .o_wr_en     (dec_wr_en),
        .o_legal     (dec_legal)
    );

    rv_regfile regfile_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rs1      (dec_rs1),
        .i_rs2      (dec_rs2),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data),
        .i_wr_en    (ex_write),
        .i_rd       (ex_rd),
        .i_wr_data  (ex_result)
    );

    // Never stalls, so the head is taken as soon as it shows up
    assign o_pop = i_valid;

    // Forward the execute-stage result to the issuing instruction
    assign issue_rs1_val = (ex_write && (ex_rd == dec_rs1)) ? ex_result : rf_rs1_data;
    assign issue_rs2_val = (ex_write && (ex_rd == dec_rs2)) ? ex_result : rf_rs2_data;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            // issue slot is dropped when the older instruction redirects
            ex_valid <= i_valid & ~o_redirect;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= i_pc;
        ex_rs1_val   <= issue_rs1_val;
        ex_rs2_val   <= issue_rs2_val;
        ex_imm       <= dec_imm;
        ex_alu_op    <= dec_alu_op;
        ex_use_imm   <= dec_use_imm;
        ex_is_branch <= dec_is_branch & dec_legal;
        ex_branch_ne <= dec_branch_ne;
        ex_is_jal    <= dec_is_jal & dec_legal;
        ex_wr_en     <= dec_wr_en & dec_legal;
        ex_rd        <= dec_rd;
    end

    assign alu_b = ex_use_imm ? ex_imm : ex_rs2_val;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:    alu_result = ex_rs1_val + alu_b;
            ALU_SUB:    alu_result = ex_rs1_val - alu_b;
            ALU_AND:    alu_result = ex_rs1_val & alu_b;
            ALU_OR:     alu_result = ex_rs1_val | alu_b;
            ALU_XOR:    alu_result = ex_rs1_val ^ alu_b;
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = '0;
        endcase
    end

    // JAL links pc plus 4
    assign ex_result = ex_is_jal ? (ex_pc + INSTR_BYTES) : alu_result;
    assign ex_write  = ex_valid & ex_wr_en;

    assign branch_taken  = ex_is_branch & ((ex_rs1_val == ex_rs2_val) ^ ex_branch_ne);
    assign o_redirect    = ex_valid & (branch_taken | ex_is_jal);
    assign o_redirect_pc = ex_pc + ex_imm;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_retire_valid <= 1'b0;
        end else begin
            o_retire_valid <= ex_valid;
        end
    end

    // Branches and no-ops report rd and data as zero
    always_ff @(posedge clk) begin
        o_retire_pc   <= ex_pc;
        o_retire_rd   <= ex_wr_en ? ex_rd : '0;
        o_retire_data <= ex_wr_en ? ex_result : '0;
    end

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire [rv_pkg::REG_AW-1:0]  i_rs1,
    input  wire [rv_pkg::REG_AW-1:0]  i_rs2,
    output logic [rv_pkg::XLEN-1:0]   o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]   o_rs2_data,
    input  wire                       i_wr_en,
    input  wire [rv_pkg::REG_AW-1:0]  i_rd,
    input  wire [rv_pkg::XLEN-1:0]    i_wr_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_rd != '0)) begin
            regs[i_rd] <= i_wr_data;
        end
    end

    // x0 always reads as zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire [rv_pkg::XLEN-1:0]       i_instr,
    output logic [rv_pkg::REG_AW-1:0]    o_rs1,
    output logic [rv_pkg::REG_AW-1:0]    o_rs2,
    output logic [rv_pkg::REG_AW-1:0]    o_rd,
    output logic [rv_pkg::ALU_OP_W-1:0]  o_alu_op,
    output logic                         o_use_imm,
    output logic [rv_pkg::XLEN-1:0]      o_imm,
    output logic                         o_is_branch,
    output logic                         o_branch_ne,
    output logic                         o_is_jal,
    output logic                         o_wr_en,
    output logic                         o_legal
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic            writes_rd;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign o_rd  = i_instr[11:7];
    assign o_rs1 = i_instr[19:15];
    assign o_rs2 = i_instr[24:20];

    // Immediate formats
    assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_b = {{(XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_j = {{(XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        o_alu_op  = ALU_ADD;
        o_use_imm = 1'b0;
        o_imm     = imm_i;
        o_legal   = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            OPC_OP: begin
                writes_rd = 1'b1;
                if (funct7 == F7_SUB) begin
                    o_alu_op = ALU_SUB;
                    o_legal  = (funct3 == F3_ADD_SUB);
                end else begin
                    o_legal = (funct7 == F7_BASE);
                    case (funct3)
                        F3_ADD_SUB: o_alu_op = ALU_ADD;
                        F3_XOR:     o_alu_op = ALU_XOR;
                        F3_OR:      o_alu_op = ALU_OR;
                        F3_AND:     o_alu_op = ALU_AND;
                        default:    o_legal  = 1'b0;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                writes_rd = 1'b1;
                o_use_imm = 1'b1;
                o_legal   = (funct3 == F3_ADD_SUB);   // only ADDI
            end
            OPC_LUI: begin
                writes_rd = 1'b1;
                o_use_imm = 1'b1;
                o_imm     = imm_u;
                o_alu_op  = ALU_PASS_B;
                o_legal   = 1'b1;
            end
            OPC_BRANCH: begin
                o_imm   = imm_b;
                o_legal = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            end
            OPC_JAL: begin
                writes_rd = 1'b1;
                o_imm     = imm_j;
                o_legal   = 1'b1;
            end
            default: o_legal = 1'b0;
        endcase
    end

    assign o_is_branch = (opcode == OPC_BRANCH);
    assign o_branch_ne = (funct3 == F3_BNE);
    assign o_is_jal    = (opcode == OPC_JAL);

    // No write for x0 targets
    assign o_wr_en = writes_rd & (o_rd != '0);

endmodule

`default_nettype wire

// ==== src/rv_fetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_queue (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_push,
    input  wire [rv_pkg::XLEN-1:0]  i_push_pc,
    input  wire [rv_pkg::XLEN-1:0]  i_push_instr,
    input  wire                     i_pop,
    input  wire                     i_flush,
    output logic                    o_full,
    output logic                    o_valid,
    output logic [rv_pkg::XLEN-1:0] o_head_pc,
    output logic [rv_pkg::XLEN-1:0] o_head_instr
);
    import rv_pkg::*;

    logic [XLEN-1:0]        pc_mem    [QUEUE_DEPTH];
    logic [XLEN-1:0]        instr_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    function automatic logic [QUEUE_PTR_W-1:0] ptr_inc(input logic [QUEUE_PTR_W-1:0] ptr);
        if (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_full  = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
    assign o_valid = (count != '0);

    assign do_push = i_push & ~o_full & ~i_flush;
    assign do_pop  = i_pop & o_valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]    <= i_push_pc;
            instr_mem[wr_ptr] <= i_push_instr;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Simultaneous push and pop leaves count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign o_head_pc    = pc_mem[rd_ptr];
    assign o_head_instr = instr_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== src/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_imem_ack_n,
    input  wire                     i_full,
    input  wire                     i_redirect,
    input  wire [rv_pkg::XLEN-1:0]  i_redirect_pc,
    output logic [rv_pkg::XLEN-1:0] o_imem_addr,
    output logic                    o_push
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    logic            mem_ready;
    logic            word_accepted;

    // Memory has valid data for the current address
    assign mem_ready = ~i_imem_ack_n;

    // Word goes into the queue only if there is room and no redirect
    assign word_accepted = mem_ready & ~i_full & ~i_redirect;

    assign o_push = word_accepted;

    // Redirect wins over sequential advance
    always_comb begin
        pc_d = pc_q;
        if (i_redirect) begin
            pc_d = i_redirect_pc;
        end else if (word_accepted) begin
            pc_d = pc_q + INSTR_BYTES;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // The pc doubles as the pushed address
    assign o_imem_addr = pc_q;

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Datapath widths
    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 1 << REG_AW;

    // First fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = {XLEN{1'b0}};

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 values for register-register ops
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ALU operation select
    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd5;

    // Fetch queue sizing
    localparam int QUEUE_DEPTH = 2;
    localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Instruction length in bytes
    localparam logic [XLEN-1:0] INSTR_BYTES = 4;

endpackage

`default_nettype wire
